//--- verilog/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// Storage geometry
`define FIFO_DEPTH 32
`define FIFO_WIDTH 8
`define FIFO_PTR_W 5

// One bit wider than the pointer so a level of FIFO_DEPTH fits
`define FIFO_LEVEL_W 6

// Wishbone data word
`define WB_DATA_W 32

`endif

//--- verilog/fifo_pkg.sv
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

	// Occupancy state of the FIFO core
	typedef enum logic [1:0] {
		EMPTY = 2'b00,
		OTHER = 2'b01,
		FULL  = 2'b10
	} fifo_state_e;

	// STATUS register layout, also the core's status output
	typedef struct packed {
		logic [21:0]                reserved;
		logic                       overflow;
		logic                       underflow;
		logic                       full;
		logic                       empty;
		logic [`FIFO_LEVEL_W-1:0]   level;
	} fifo_status_t;

endpackage

`default_nettype wire

//--- verilog/wb_pkg.sv
`default_nettype none

`include "fifo_consts.svh"

package wb_pkg;

	// Word index taken from adr[3:2]
	typedef enum logic [1:0] {
		DATA   = 2'd0,
		STATUS = 2'd1,
		CTRL   = 2'd2
	} wb_reg_e;

	// Write word, seen as a byte at DATA or as commands at CTRL
	typedef union packed {
		struct packed {
			logic [`WB_DATA_W-`FIFO_WIDTH-1:0] unused;
			logic [`FIFO_WIDTH-1:0]            value;
		} data;
		struct packed {
			logic [`WB_DATA_W-3:0] unused;
			logic                  clear_errs;
			logic                  flush;
		} ctrl;
	} wb_wdata_u;

	// One bus request as seen by the slave
	typedef struct packed {
		logic      we;
		wb_reg_e   idx;
		wb_wdata_u wdata;
	} wb_req_t;

endpackage

`default_nettype wire

//--- verilog/fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_ram (
	input  logic                    clk,
	input  logic                    wr_en,
	input  logic [`FIFO_PTR_W-1:0]  wr_addr,
	input  logic [`FIFO_WIDTH-1:0]  wr_data,
	input  logic                    rd_en,
	input  logic [`FIFO_PTR_W-1:0]  rd_addr,
	output logic [`FIFO_WIDTH-1:0]  rd_data
);

	logic [`FIFO_WIDTH-1:0] mem [`FIFO_DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port, holds its value between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- verilog/fifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    push,
	input  logic                    pop,
	input  logic                    flush,
	input  logic                    clear_errs,
	input  logic [`FIFO_WIDTH-1:0]  push_data,
	output logic [`FIFO_WIDTH-1:0]  pop_data,
	output fifo_pkg::fifo_status_t  status
);

	localparam logic [`FIFO_PTR_W-1:0]   PTR_LAST  = `FIFO_PTR_W'(`FIFO_DEPTH - 1);
	localparam logic [`FIFO_LEVEL_W-1:0] LEVEL_MAX = `FIFO_LEVEL_W'(`FIFO_DEPTH);

	fifo_pkg::fifo_state_e state;
	fifo_pkg::fifo_state_e state_nxt;

	logic [`FIFO_PTR_W-1:0]   wr_ptr;
	logic [`FIFO_PTR_W-1:0]   rd_ptr;
	logic [`FIFO_LEVEL_W-1:0] level;
	logic                     overflow;
	logic                     underflow;
	logic                     pop_zero;
	logic                     do_push;
	logic                     do_pop;
	logic [`FIFO_WIDTH-1:0]   ram_rd_data;

	// Requests that the state allows
	assign do_push = push && (state != fifo_pkg::FULL);
	assign do_pop  = pop && (state != fifo_pkg::EMPTY);

	fifo_ram u_ram (
		.clk     (clk),
		.wr_en   (do_push),
		.wr_addr (wr_ptr),
		.wr_data (push_data),
		.rd_en   (do_pop),
		.rd_addr (rd_ptr),
		.rd_data (ram_rd_data)
	);

	// EMPTY / OTHER / FULL transitions
	always_comb begin
		state_nxt = state;
		if (flush) begin
			state_nxt = fifo_pkg::EMPTY;
		end else begin
			case (state)
				fifo_pkg::EMPTY: begin
					if (push) begin
						state_nxt = fifo_pkg::OTHER;
					end
				end
				fifo_pkg::OTHER: begin
					if (push && level == LEVEL_MAX - 1'b1) begin
						state_nxt = fifo_pkg::FULL;
					end else if (pop && level == 1) begin
						state_nxt = fifo_pkg::EMPTY;
					end
				end
				fifo_pkg::FULL: begin
					if (pop) begin
						state_nxt = fifo_pkg::OTHER;
					end
				end
				default: state_nxt = fifo_pkg::EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fifo_pkg::EMPTY;
		end else begin
			state <= state_nxt;
		end
	end

	// Pointers and fill level
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else if (do_push) begin
			wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			level  <= level + 1'b1;
		end else if (do_pop) begin
			rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			level  <= level - 1'b1;
		end
	end

	// Sticky error bits, cleared only by command
	always_ff @(posedge clk) begin
		if (rst || clear_errs) begin
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			if (push && state == fifo_pkg::FULL) begin
				overflow <= 1'b1;
			end
			if (pop && state == fifo_pkg::EMPTY) begin
				underflow <= 1'b1;
			end
		end
	end

	// Remember whether the last pop found nothing
	always_ff @(posedge clk) begin
		if (rst) begin
			pop_zero <= 1'b0;
		end else if (pop) begin
			pop_zero <= (state == fifo_pkg::EMPTY);
		end
	end

	assign pop_data = pop_zero ? '0 : ram_rd_data;

	assign status.reserved  = '0;
	assign status.overflow  = overflow;
	assign status.underflow = underflow;
	assign status.full      = (state == fifo_pkg::FULL);
	assign status.empty     = (state == fifo_pkg::EMPTY);
	assign status.level     = level;

	a_level_bound: assert property (
		@(posedge clk) disable iff (rst) level <= LEVEL_MAX
	) else $error("fifo_ctrl: level above depth");

	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (rst) do_push |-> level < LEVEL_MAX
	) else $error("fifo_ctrl: array written while full");

	a_flags_exclusive: assert property (
		@(posedge clk) disable iff (rst) !(status.empty && status.full)
	) else $error("fifo_ctrl: empty and full both high");

	// State register and level counter must track each other
	a_state_matches_level: assert property (
		@(posedge clk) disable iff (rst)
			((state == fifo_pkg::EMPTY) == (level == 0)) &&
			((state == fifo_pkg::FULL) == (level == LEVEL_MAX))
	) else $error("fifo_ctrl: state %s with level %0d", state.name(), level);

endmodule

`default_nettype wire

//--- verilog/wb_fifo_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module wb_fifo_regs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cyc,
	input  logic                    stb,
	input  logic                    we,
	input  logic [3:0]              adr,
	input  logic [`WB_DATA_W-1:0]   dat_w,
	output logic [`WB_DATA_W-1:0]   dat_r,
	output logic                    ack,
	output logic                    push,
	output logic                    pop,
	output logic                    flush,
	output logic                    clear_errs,
	output logic [`FIFO_WIDTH-1:0]  push_data,
	input  logic [`FIFO_WIDTH-1:0]  pop_data,
	input  fifo_pkg::fifo_status_t  status
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_ACK
	} seq_state_e;

	seq_state_e      state;
	wb_pkg::wb_req_t req;
	wb_pkg::wb_reg_e rd_sel;
	logic            rd_we;
	logic            accept;
	logic            is_data_read;

	// Current bus request
	assign req.we    = we;
	assign req.idx   = wb_pkg::wb_reg_e'(adr[3:2]);
	assign req.wdata = dat_w;

	assign accept       = (state == ST_IDLE) && cyc && stb;
	assign is_data_read = !req.we && (req.idx == wb_pkg::DATA);

	// Writes act at the sampling edge
	assign push       = accept && req.we && (req.idx == wb_pkg::DATA);
	assign push_data  = req.wdata.data.value;
	assign flush      = accept && req.we && (req.idx == wb_pkg::CTRL) && req.wdata.ctrl.flush;
	assign clear_errs = accept && req.we && (req.idx == wb_pkg::CTRL)
		&& req.wdata.ctrl.clear_errs;

	// Sequencer, a DATA read waits one extra cycle for the array
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			pop   <= 1'b0;
		end else begin
			pop <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cyc && stb) begin
						if (is_data_read) begin
							state <= ST_WAIT;
							pop   <= 1'b1;
						end else begin
							state <= ST_ACK;
						end
					end
				end
				ST_WAIT: state <= ST_ACK;
				ST_ACK:  state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Which register answers on the acknowledge
	always_ff @(posedge clk) begin
		if (accept) begin
			rd_sel <= req.idx;
			rd_we  <= req.we;
		end
	end

	assign ack = (state == ST_ACK);

	always_comb begin
		dat_r = '0;
		if (ack && !rd_we) begin
			case (rd_sel)
				wb_pkg::DATA:   dat_r = {{(`WB_DATA_W - `FIFO_WIDTH){1'b0}}, pop_data};
				wb_pkg::STATUS: dat_r = status;
				default:        dat_r = '0;
			endcase
		end
	end

	// Master must hold the request until it sees ack
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (rst) ack |-> (cyc && stb)
	) else $error("wb_fifo_regs: ack without an active cycle");

	a_ack_single: assert property (
		@(posedge clk) disable iff (rst) ack |=> !ack
	) else $error("wb_fifo_regs: ack held longer than one cycle");

	// Registers are word aligned
	a_word_aligned: assert property (
		@(posedge clk) disable iff (rst) (cyc && stb) |-> (adr[1:0] == 2'b00)
	) else $error("wb_fifo_regs: unaligned address %h", adr);

endmodule

`default_nettype wire

//--- verilog/wb_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module wb_fifo_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [3:0]             adr,
	input  logic [`WB_DATA_W-1:0]  dat_w,
	output logic [`WB_DATA_W-1:0]  dat_r,
	output logic                   ack,
	output logic                   empty,
	output logic                   full
);

	logic                   push;
	logic                   pop;
	logic                   flush;
	logic                   clear_errs;
	logic [`FIFO_WIDTH-1:0] push_data;
	logic [`FIFO_WIDTH-1:0] pop_data;
	fifo_pkg::fifo_status_t status;

	wb_fifo_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.dat_r      (dat_r),
		.ack        (ack),
		.push       (push),
		.pop        (pop),
		.flush      (flush),
		.clear_errs (clear_errs),
		.push_data  (push_data),
		.pop_data   (pop_data),
		.status     (status)
	);

	fifo_ctrl u_fifo (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.pop        (pop),
		.flush      (flush),
		.clear_errs (clear_errs),
		.push_data  (push_data),
		.pop_data   (pop_data),
		.status     (status)
	);

	// Interrupt-style level outputs
	assign empty = status.empty;
	assign full  = status.full;

endmodule

`default_nettype wire

//--- verification/wb_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module wb_fifo_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	localparam int ACK_LIMIT    = 8;
	localparam int RANDOM_OPS   = 300;
	// Bus operations per directed test: reset, order, full, empty, flush
	localparam int DIRECTED_OPS = 1 + 40 + 68 + 6 + 14;
	// No access takes more than four clock cycles
	localparam int WATCHDOG_NS  =
		(RESET_CYCLES + (DIRECTED_OPS + RANDOM_OPS) * 4 + 50) * CLK_PERIOD;

	logic                  clk;
	logic                  rst;
	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [3:0]            adr;
	logic [`WB_DATA_W-1:0] dat_w;
	logic [`WB_DATA_W-1:0] dat_r;
	logic                  ack;
	logic                  empty;
	logic                  full;

	// Reference model of the FIFO contents and sticky bits
	logic [`FIFO_WIDTH-1:0] fifo_q[$];
	logic                   m_ovf;
	logic                   m_unf;
	logic                   exp_empty;
	logic                   exp_full;
	logic                   check_rd;
	logic [`WB_DATA_W-1:0]  exp_dat;

	int value_errs;
	int proto_errs;
	int reads_checked;
	int seed;

	wb_fifo_top uut (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack),
		.empty (empty),
		.full  (full)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Read data seen at the acknowledge
	a_read_value: assert property (
		@(posedge clk) disable iff (rst) (ack && check_rd) |-> (dat_r == exp_dat)
	) else begin
		value_errs++;
		$display("** Error at %0t ns: dat_r expected %h, got %h",
			$time, $sampled(exp_dat), $sampled(dat_r));
	end

	// Flags only compared between accesses
	a_empty_flag: assert property (
		@(posedge clk) disable iff (rst) !cyc |-> (empty == exp_empty)
	) else begin
		value_errs++;
		$display("** Error at %0t ns: empty expected %b, got %b",
			$time, $sampled(exp_empty), $sampled(empty));
	end

	a_full_flag: assert property (
		@(posedge clk) disable iff (rst) !cyc |-> (full == exp_full)
	) else begin
		value_errs++;
		$display("** Error at %0t ns: full expected %b, got %b",
			$time, $sampled(exp_full), $sampled(full));
	end

	a_no_stray_ack: assert property (
		@(posedge clk) disable iff (rst) !cyc |-> !ack
	) else begin
		proto_errs++;
		$display("Protocol failure at %0t ns: ack raised with no bus cycle open", $time);
	end

	// One Wishbone classic access, released after the ack edge
	task automatic bus_access(input wb_pkg::wb_req_t req, input logic check,
			input logic [`WB_DATA_W-1:0] expect_val);
		int waited;
		waited = 0;
		@(negedge clk);
		check_rd = check;
		exp_dat  = expect_val;
		cyc      = 1'b1;
		stb      = 1'b1;
		we       = req.we;
		adr      = {req.idx, 2'b00};
		dat_w    = req.wdata;
		@(negedge clk);
		while (!ack && waited < ACK_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (!ack) begin
			proto_errs++;
			$display("Protocol failure at %0t ns: no ack within %0d cycles", $time, ACK_LIMIT);
		end else if (check) begin
			reads_checked++;
		end
		@(negedge clk);
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		check_rd  = 1'b0;
		exp_empty = (fifo_q.size() == 0);
		exp_full  = (fifo_q.size() == `FIFO_DEPTH);
	endtask

	task automatic wb_write(input wb_pkg::wb_reg_e idx, input logic [`WB_DATA_W-1:0] word);
		wb_pkg::wb_req_t req;
		req.we    = 1'b1;
		req.idx   = idx;
		req.wdata = word;
		bus_access(req, 1'b0, '0);
	endtask

	task automatic wb_read(input wb_pkg::wb_reg_e idx, input logic [`WB_DATA_W-1:0] expect_val);
		wb_pkg::wb_req_t req;
		req.we    = 1'b0;
		req.idx   = idx;
		req.wdata = '0;
		bus_access(req, 1'b1, expect_val);
	endtask

	function automatic fifo_pkg::fifo_status_t predicted_status();
		fifo_pkg::fifo_status_t s;
		s           = '0;
		s.overflow  = m_ovf;
		s.underflow = m_unf;
		s.full      = (fifo_q.size() == `FIFO_DEPTH);
		s.empty     = (fifo_q.size() == 0);
		s.level     = `FIFO_LEVEL_W'(fifo_q.size());
		return s;
	endfunction

	task automatic push_byte(input logic [`FIFO_WIDTH-1:0] b);
		wb_pkg::wb_wdata_u w;
		w            = '0;
		w.data.value = b;
		// A full FIFO drops the byte
		if (fifo_q.size() == `FIFO_DEPTH) begin
			m_ovf = 1'b1;
		end else begin
			fifo_q.push_back(b);
		end
		wb_write(wb_pkg::DATA, w);
	endtask

	task automatic pop_byte();
		logic [`FIFO_WIDTH-1:0] b;
		if (fifo_q.size() == 0) begin
			b     = '0;
			m_unf = 1'b1;
		end else begin
			b = fifo_q.pop_front();
		end
		wb_read(wb_pkg::DATA, {{(`WB_DATA_W - `FIFO_WIDTH){1'b0}}, b});
	endtask

	task automatic check_status();
		wb_read(wb_pkg::STATUS, predicted_status());
	endtask

	task automatic send_ctrl(input logic do_flush, input logic do_clear);
		wb_pkg::wb_wdata_u w;
		w                 = '0;
		w.ctrl.flush      = do_flush;
		w.ctrl.clear_errs = do_clear;
		if (do_flush) begin
			fifo_q.delete();
		end
		if (do_clear) begin
			m_ovf = 1'b0;
			m_unf = 1'b0;
		end
		wb_write(wb_pkg::CTRL, w);
	endtask

	task automatic random_traffic(input int count);
		int pick;
		for (int i = 0; i < count; i++) begin
			pick = {$random(seed)} % 8;
			if (pick < 3) begin
				push_byte(8'($random(seed)));
			end else if (pick < 6) begin
				pop_byte();
			end else begin
				check_status();
			end
		end
	endtask

	initial begin
		rst           = 1'b1;
		cyc           = 1'b0;
		stb           = 1'b0;
		we            = 1'b0;
		adr           = '0;
		dat_w         = '0;
		m_ovf         = 1'b0;
		m_unf         = 1'b0;
		exp_empty     = 1'b1;
		exp_full      = 1'b0;
		check_rd      = 1'b0;
		exp_dat       = '0;
		value_errs    = 0;
		proto_errs    = 0;
		reads_checked = 0;
		seed          = 88;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		check_status();

		// Ten bytes through in order, level tracked after each access
		for (int i = 0; i < 10; i++) begin
			push_byte(8'hA0 + 8'(i));
			check_status();
		end
		for (int i = 0; i < 10; i++) begin
			pop_byte();
			check_status();
		end

		// Fill to the top, then one push too many
		for (int i = 0; i < `FIFO_DEPTH; i++) begin
			push_byte(8'(i * 37 + 5));
		end
		check_status();
		push_byte(8'hEE);
		check_status();
		for (int i = 0; i < `FIFO_DEPTH; i++) begin
			pop_byte();
		end
		check_status();

		// Underflow joins the overflow, both stay until cleared
		pop_byte();
		check_status();
		pop_byte();
		check_status();
		send_ctrl(1'b0, 1'b1);
		check_status();

		// Flush with data present
		for (int i = 0; i < 4; i++) begin
			push_byte(8'h5A ^ 8'(i));
		end
		send_ctrl(1'b1, 1'b0);
		check_status();
		push_byte(8'hC3);
		pop_byte();
		check_status();

		// Flush and clear in one write
		pop_byte();
		push_byte(8'h12);
		push_byte(8'h34);
		send_ctrl(1'b1, 1'b1);
		check_status();

		random_traffic(RANDOM_OPS);

		$display("Reads compared: %0d, value errors: %0d, protocol errors: %0d",
			reads_checked, value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run still going after %0d ns", WATCHDOG_NS);
		$display("Reads compared: %0d, value errors: %0d, protocol errors: %0d",
			reads_checked, value_errs, proto_errs);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/fifo_pkg.sv
verilog/wb_pkg.sv
verilog/fifo_ram.sv
verilog/fifo_ctrl.sv
verilog/wb_fifo_regs.sv
verilog/wb_fifo_top.sv
verification/wb_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Wishbone FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module wb_fifo_tb

./obj_dir/Vwb_fifo_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failures"
